/* logic/rv64_isa_pkg.sv */
`default_nettype none

package rv64_isa_pkg;

  // data and address word.
  typedef logic [63:0] xlen_t;

  // one fetched instruction.
  typedef logic [31:0] inst_t;

  typedef logic [4:0] reg_addr_t;

  // major opcodes of the supported subset.
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for the integer ALU group.
  typedef enum logic [2:0] {
    F3_ADD = 3'b000,
    F3_SLT = 3'b010,
    F3_XOR = 3'b100,
    F3_OR  = 3'b110,
    F3_AND = 3'b111
  } funct3_e;

  localparam inst_t EBREAK_INST = 32'h0010_0073;

  localparam xlen_t DEFAULT_RESET_PC = 64'h0000_0000_8000_0000;

endpackage

`default_nettype wire

/* logic/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_SLT    = 3'd2,
    ALU_XOR    = 3'd3,
    ALU_OR     = 3'd4,
    ALU_AND    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } src_a_e;

  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } src_b_e;

  // one instruction in flight, so three phases are enough.
  typedef enum logic [1:0] {
    F_REQ     = 2'd0,
    F_RELEASE = 2'd1,
    F_EXEC    = 2'd2
  } fetch_state_e;

  typedef struct packed {
    alu_op_e alu_op;
    src_a_e  src_a;
    src_b_e  src_b;
    logic    reg_wen;
    logic    wb_link;
    logic    jump;
    logic    is_jalr;
  } ctrl_t;

endpackage

`default_nettype wire

/* logic/gpr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface gpr_if;
  import rv64_isa_pkg::*;

  reg_addr_t raddr1;
  reg_addr_t raddr2;
  xlen_t     rdata1;
  xlen_t     rdata2;
  reg_addr_t waddr;
  xlen_t     wdata;
  logic      wen;

  modport core_mp (
    output raddr1, raddr2, waddr, wdata, wen,
    input  rdata1, rdata2
  );

  modport rf_mp (
    input  raddr1, raddr2, waddr, wdata, wen,
    output rdata1, rdata2
  );

endinterface

`default_nettype wire

/* logic/pc_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_fetch #(
  parameter rv64_isa_pkg::xlen_t RESET_PC = rv64_isa_pkg::DEFAULT_RESET_PC
) (
  input  wire                      clk,
  input  wire                      rst_i,
  input  wire                      imem_ack_i,
  input  wire rv64_isa_pkg::inst_t imem_data_i,
  input  wire                      jump_i,
  input  wire rv64_isa_pkg::xlen_t target_i,
  input  wire                      ebreak_i,
  output logic                     imem_req_o,
  output rv64_isa_pkg::xlen_t      imem_addr_o,
  output rv64_isa_pkg::inst_t      inst_o,
  output rv64_isa_pkg::xlen_t      pc_o,
  output rv64_isa_pkg::xlen_t      pc_plus4_o,
  output logic                     exec_o,
  output logic                     halt_o
);
  import rv64_isa_pkg::*;
  import core_ctrl_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         req_q;
  logic         halt_q;
  logic         halt_d;
  logic         take_inst;
  xlen_t        pc_q;
  xlen_t        pc_plus4;
  inst_t        inst_q;

  assign pc_plus4  = pc_q + 64'd4;
  assign take_inst = (state_q == F_REQ) && req_q && imem_ack_i;

  always_comb begin
    state_d = state_q;
    halt_d  = halt_q;
    case (state_q)
      F_REQ: begin
        if (take_inst) begin
          state_d = F_RELEASE;
        end
      end
      // memory must drop ack before the next request.
      F_RELEASE: begin
        if (!imem_ack_i) begin
          state_d = F_EXEC;
        end
      end
      F_EXEC: begin
        state_d = F_REQ;
        if (ebreak_i) begin
          halt_d = 1'b1;
        end
      end
      default: state_d = F_REQ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= F_REQ;
      req_q   <= 1'b0;
      halt_q  <= 1'b0;
      pc_q    <= RESET_PC;
    end else begin
      state_q <= state_d;
      halt_q  <= halt_d;
      // request follows the next state, never while halted.
      req_q   <= (state_d == F_REQ) && !halt_d;
      if (state_q == F_EXEC) begin
        pc_q <= jump_i ? target_i : pc_plus4;
      end
    end
  end

  // instruction latch.
  always_ff @(posedge clk) begin
    if (take_inst) begin
      inst_q <= imem_data_i;
    end
  end

  assign imem_req_o  = req_q;
  assign imem_addr_o = pc_q;
  assign inst_o      = inst_q;
  assign pc_o        = pc_q;
  assign pc_plus4_o  = pc_plus4;
  assign exec_o      = (state_q == F_EXEC);
  assign halt_o      = halt_q;

endmodule

`default_nettype wire

/* logic/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
  input  wire rv64_isa_pkg::inst_t inst_i,
  output rv64_isa_pkg::reg_addr_t  rs1_o,
  output rv64_isa_pkg::reg_addr_t  rs2_o,
  output rv64_isa_pkg::reg_addr_t  rd_o,
  output rv64_isa_pkg::xlen_t      imm_o,
  output core_ctrl_pkg::ctrl_t     ctrl_o,
  output logic                     ebreak_o
);
  import rv64_isa_pkg::*;
  import core_ctrl_pkg::*;

  opcode_e opcode;
  funct3_e funct3;
  logic    [6:0] funct7;
  xlen_t   imm_i;
  xlen_t   imm_u;
  xlen_t   imm_j;
  alu_op_e f3_op;
  logic    f3_ok;
  ctrl_t   ctrl;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = funct3_e'(inst_i[14:12]);
  assign funct7 = inst_i[31:25];

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  // shared funct3 map for the register and immediate forms.
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      F3_ADD: f3_op = ALU_ADD;
      F3_SLT: f3_op = ALU_SLT;
      F3_XOR: f3_op = ALU_XOR;
      F3_OR:  f3_op = ALU_OR;
      F3_AND: f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    // anything unknown falls through as a quiet no-op.
    ctrl = '{alu_op: ALU_ADD, src_a: A_ZERO, src_b: B_IMM, default: 1'b0};
    imm_o = imm_i;
    case (opcode)
      OP_IMM: begin
        ctrl.alu_op  = f3_op;
        ctrl.src_a   = A_RS1;
        ctrl.reg_wen = f3_ok;
      end
      OP: begin
        ctrl.src_a = A_RS1;
        ctrl.src_b = B_RS2;
        if (funct7 == 7'b0000000) begin
          ctrl.alu_op  = f3_op;
          ctrl.reg_wen = f3_ok;
        end else if (funct7 == 7'b0100000 && funct3 == F3_ADD) begin
          ctrl.alu_op  = ALU_SUB;
          ctrl.reg_wen = 1'b1;
        end
      end
      LUI: begin
        imm_o        = imm_u;
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.reg_wen = 1'b1;
      end
      AUIPC: begin
        imm_o        = imm_u;
        ctrl.src_a   = A_PC;
        ctrl.reg_wen = 1'b1;
      end
      JAL: begin
        imm_o        = imm_j;
        ctrl.src_a   = A_PC;
        ctrl.reg_wen = 1'b1;
        ctrl.wb_link = 1'b1;
        ctrl.jump    = 1'b1;
      end
      JALR: begin
        if (funct3 == F3_ADD) begin
          ctrl.src_a   = A_RS1;
          ctrl.reg_wen = 1'b1;
          ctrl.wb_link = 1'b1;
          ctrl.jump    = 1'b1;
          ctrl.is_jalr = 1'b1;
        end
      end
      default: ;
    endcase
  end

  assign rs1_o    = inst_i[19:15];
  assign rs2_o    = inst_i[24:20];
  assign rd_o     = inst_i[11:7];
  assign ctrl_o   = ctrl;
  assign ebreak_o = (inst_i == EBREAK_INST);

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire core_ctrl_pkg::ctrl_t ctrl_i,
  input  wire rv64_isa_pkg::xlen_t  rs1_data_i,
  input  wire rv64_isa_pkg::xlen_t  rs2_data_i,
  input  wire rv64_isa_pkg::xlen_t  pc_i,
  input  wire rv64_isa_pkg::xlen_t  imm_i,
  output rv64_isa_pkg::xlen_t       result_o
);
  import rv64_isa_pkg::*;
  import core_ctrl_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t res;

  always_comb begin
    case (ctrl_i.src_a)
      A_RS1:   op_a = rs1_data_i;
      A_PC:    op_a = pc_i;
      default: op_a = '0;
    endcase
  end

  assign op_b = (ctrl_i.src_b == B_IMM) ? imm_i : rs2_data_i;

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD:    res = op_a + op_b;
      ALU_SUB:    res = op_a - op_b;
      ALU_SLT:    res = {63'b0, $signed(op_a) < $signed(op_b)};
      ALU_XOR:    res = op_a ^ op_b;
      ALU_OR:     res = op_a | op_b;
      ALU_AND:    res = op_a & op_b;
      ALU_PASS_B: res = op_b;
      default:    res = '0;
    endcase
  end

  // jalr target has bit 0 forced low.
  assign result_o = ctrl_i.is_jalr ? {res[63:1], 1'b0} : res;

endmodule

`default_nettype wire

/* logic/gpr.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr (
  input wire  clk,
  input wire  rst_i,
  gpr_if.rf_mp rf
);
  import rv64_isa_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.wen && rf.waddr != 5'd0) begin
      regs[rf.waddr] <= rf.wdata;
    end
  end

  // x0 always reads zero.
  assign rf.rdata1 = (rf.raddr1 == 5'd0) ? '0 : regs[rf.raddr1];
  assign rf.rdata2 = (rf.raddr2 == 5'd0) ? '0 : regs[rf.raddr2];

endmodule

`default_nettype wire

/* logic/rv64_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64_core #(
  parameter rv64_isa_pkg::xlen_t RESET_PC = rv64_isa_pkg::DEFAULT_RESET_PC
) (
  input  wire                          clk,
  input  wire                          rst_i,
  output logic                         imem_req_o,
  output rv64_isa_pkg::xlen_t          imem_addr_o,
  input  wire                          imem_ack_i,
  input  wire rv64_isa_pkg::inst_t     imem_data_i,
  output logic                         retire_valid_o,
  output rv64_isa_pkg::xlen_t          retire_pc_o,
  output rv64_isa_pkg::reg_addr_t      retire_rd_o,
  output rv64_isa_pkg::xlen_t          retire_data_o,
  output logic                         halt_o
);
  import rv64_isa_pkg::*;
  import core_ctrl_pkg::*;

  inst_t     inst;
  xlen_t     pc;
  xlen_t     pc_plus4;
  logic      exec;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  xlen_t     imm;
  ctrl_t     ctrl;
  logic      ebreak;
  xlen_t     alu_result;
  xlen_t     wb_data;
  logic      rf_wen;

  gpr_if u_gpr_if ();

  pc_fetch #(
    .RESET_PC (RESET_PC)
  ) u_pc_fetch (
    .clk         (clk),
    .rst_i       (rst_i),
    .imem_ack_i  (imem_ack_i),
    .imem_data_i (imem_data_i),
    .jump_i      (ctrl.jump),
    .target_i    (alu_result),
    .ebreak_i    (ebreak),
    .imem_req_o  (imem_req_o),
    .imem_addr_o (imem_addr_o),
    .inst_o      (inst),
    .pc_o        (pc),
    .pc_plus4_o  (pc_plus4),
    .exec_o      (exec),
    .halt_o      (halt_o)
  );

  inst_decode u_inst_decode (
    .inst_i   (inst),
    .rs1_o    (rs1),
    .rs2_o    (rs2),
    .rd_o     (rd),
    .imm_o    (imm),
    .ctrl_o   (ctrl),
    .ebreak_o (ebreak)
  );

  alu u_alu (
    .ctrl_i     (ctrl),
    .rs1_data_i (u_gpr_if.rdata1),
    .rs2_data_i (u_gpr_if.rdata2),
    .pc_i       (pc),
    .imm_i      (imm),
    .result_o   (alu_result)
  );

  gpr u_gpr (
    .clk   (clk),
    .rst_i (rst_i),
    .rf    (u_gpr_if.rf_mp)
  );

  // link writes take pc+4, everything else the alu.
  assign wb_data = ctrl.wb_link ? pc_plus4 : alu_result;
  assign rf_wen  = exec && ctrl.reg_wen;

  assign u_gpr_if.raddr1 = rs1;
  assign u_gpr_if.raddr2 = rs2;
  assign u_gpr_if.waddr  = rd;
  assign u_gpr_if.wdata  = wb_data;
  assign u_gpr_if.wen    = rf_wen;

  // retire trace, one pulse per instruction.
  assign retire_valid_o = exec;
  assign retire_pc_o    = pc;
  assign retire_rd_o    = ctrl.reg_wen ? rd : 5'd0;
  assign retire_data_o  = (rf_wen && rd != 5'd0) ? wb_data : '0;

endmodule

`default_nettype wire

/* verif/rv64_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64_core_props (
  input wire                      clk,
  input wire                      rst_i,
  input wire                      imem_req_o,
  input wire                      imem_ack_i,
  input wire rv64_isa_pkg::xlen_t imem_addr_o,
  input wire                      retire_valid_o,
  input wire                      halt_o
);

  // request holds until the memory answers.
  req_held: assert property (@(posedge clk) disable iff (rst_i)
    imem_req_o && !imem_ack_i |=> imem_req_o)
    else $error("fetch request dropped before ack");

  addr_stable: assert property (@(posedge clk) disable iff (rst_i)
    imem_req_o |=> !imem_req_o || $stable(imem_addr_o))
    else $error("fetch address changed during a request");

  retire_single: assert property (@(posedge clk) disable iff (rst_i)
    retire_valid_o |=> !retire_valid_o)
    else $error("retire pulse longer than one cycle");

  no_req_halted: assert property (@(posedge clk) disable iff (rst_i)
    halt_o |-> !imem_req_o)
    else $error("fetch request while halted");

endmodule

bind rv64_core rv64_core_props u_rv64_core_props (
  .clk            (clk),
  .rst_i          (rst_i),
  .imem_req_o     (imem_req_o),
  .imem_ack_i     (imem_ack_i),
  .imem_addr_o    (imem_addr_o),
  .retire_valid_o (retire_valid_o),
  .halt_o         (halt_o)
);

`default_nettype wire

/* verif/rv64_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64_core_tb;
  import rv64_isa_pkg::*;

  localparam xlen_t START_PC     = 64'h0000_0000_8000_0000;
  localparam inst_t EBREAK_WORD  = 32'h0010_0073;
  localparam int    EBREAK_AFTER = 300;
  localparam int    WAIT_LIMIT   = 200;
  localparam int    RUN_LIMIT    = 20000;

  logic      clk;
  logic      rst_i;
  logic      imem_req_o;
  xlen_t     imem_addr_o;
  logic      imem_ack_i;
  inst_t     imem_data_i;
  logic      retire_valid_o;
  xlen_t     retire_pc_o;
  reg_addr_t retire_rd_o;
  xlen_t     retire_data_o;
  logic      halt_o;

  integer seed;
  int     check_errors;
  int     timeout_errors;
  int     retire_count;
  int     served_count;
  logic   stop_run;
  logic   ebreak_retired;
  logic   prev_req;
  logic   ack_at_edge;
  inst_t  served_inst;
  inst_t  imem [xlen_t];
  xlen_t  model_regs [32];
  xlen_t  model_pc;

  rv64_core u_rv64_core (
    .clk            (clk),
    .rst_i          (rst_i),
    .imem_req_o     (imem_req_o),
    .imem_addr_o    (imem_addr_o),
    .imem_ack_i     (imem_ack_i),
    .imem_data_i    (imem_data_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o),
    .halt_o         (halt_o)
  );

  always #10 clk = ~clk;

  task automatic report_mismatch(input string name, input xlen_t exp, input xlen_t act);
    check_errors++;
    $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  function automatic int rand_range(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [2:0] pick_funct3();
    case (rand_range(5))
      0: return 3'b000;
      1: return 3'b010;
      2: return 3'b100;
      3: return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  // random instruction from the supported subset.
  function automatic inst_t gen_inst();
    int          kind;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] jimm12;
    logic [20:0] jimm21;
    inst_t       inst;
    kind   = rand_range(11);
    rd     = reg_addr_t'(rand_range(8));
    rs1    = reg_addr_t'(rand_range(8));
    rs2    = reg_addr_t'(rand_range(8));
    f3     = pick_funct3();
    jimm12 = 12'((rand_range(33) - 16) * 4);
    jimm21 = 21'((rand_range(33) - 16) * 4);
    case (kind)
      0, 1, 2, 3: inst = {12'($random(seed)), rs1, f3, rd, 7'h13};
      4, 5, 6: begin
        if (rand_range(4) == 0) begin
          inst = {7'b0100000, rs2, rs1, 3'b000, rd, 7'h33};
        end else begin
          inst = {7'b0000000, rs2, rs1, f3, rd, 7'h33};
        end
      end
      7: inst = {20'($random(seed)), rd, 7'h37};
      8: inst = {20'($random(seed)), rd, 7'h17};
      9: inst = {jimm21[20], jimm21[10:1], jimm21[11], jimm21[19:12], rd, 7'h6f};
      default: inst = {jimm12, rs1, 3'b000, rd, 7'h67};
    endcase
    return inst;
  endfunction

  function automatic xlen_t alu_ref(input logic [2:0] f3, input xlen_t a, input xlen_t b);
    case (f3)
      3'b000: return a + b;
      3'b010: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      3'b100: return a ^ b;
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // reference execution of one instruction at model_pc.
  task automatic execute_model(input inst_t inst, output reg_addr_t exp_rd,
                               output xlen_t exp_data);
    logic [6:0] opc;
    logic [6:0] f7;
    logic [2:0] f3;
    logic       f3_ok;
    logic       wen;
    reg_addr_t  rd;
    xlen_t      a;
    xlen_t      b;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_j;
    xlen_t      val;
    xlen_t      next_pc;
    opc     = inst[6:0];
    f7      = inst[31:25];
    f3      = inst[14:12];
    f3_ok   = (f3 != 3'b001) && (f3 != 3'b011) && (f3 != 3'b101);
    rd      = inst[11:7];
    a       = model_regs[inst[19:15]];
    b       = model_regs[inst[24:20]];
    imm_i   = {{52{inst[31]}}, inst[31:20]};
    imm_u   = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j   = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    wen     = 1'b0;
    val     = 64'd0;
    next_pc = model_pc + 64'd4;
    case (opc)
      7'h13: begin
        wen = f3_ok;
        val = alu_ref(f3, a, imm_i);
      end
      7'h33: begin
        if (f7 == 7'h00 && f3_ok) begin
          wen = 1'b1;
          val = alu_ref(f3, a, b);
        end else if (f7 == 7'h20 && f3 == 3'b000) begin
          wen = 1'b1;
          val = a - b;
        end
      end
      7'h37: begin
        wen = 1'b1;
        val = imm_u;
      end
      7'h17: begin
        wen = 1'b1;
        val = model_pc + imm_u;
      end
      7'h6f: begin
        wen     = 1'b1;
        val     = model_pc + 64'd4;
        next_pc = model_pc + imm_j;
      end
      7'h67: begin
        if (f3 == 3'b000) begin
          wen     = 1'b1;
          val     = model_pc + 64'd4;
          next_pc = (a + imm_i) & ~64'd1;
        end
      end
      default: ;
    endcase
    exp_rd   = wen ? rd : 5'd0;
    exp_data = (wen && rd != 5'd0) ? val : 64'd0;
    if (wen && rd != 5'd0) begin
      model_regs[rd] = val;
    end
    model_pc = next_pc;
  endtask

  task automatic check_retire();
    reg_addr_t exp_rd;
    xlen_t     exp_data;
    if (retire_pc_o !== model_pc) begin
      report_mismatch("retire_pc_o", model_pc, retire_pc_o);
    end
    execute_model(served_inst, exp_rd, exp_data);
    if (retire_rd_o !== exp_rd) begin
      report_mismatch("retire_rd_o", 64'(exp_rd), 64'(retire_rd_o));
    end
    if (retire_data_o !== exp_data) begin
      report_mismatch("retire_data_o", exp_data, retire_data_o);
    end
    retire_count++;
    if (served_inst == EBREAK_WORD) begin
      ebreak_retired = 1'b1;
    end
  endtask

  task automatic end_run();
    $display("errors: %0d check failures, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  // ack level as the core saw it at the last rising edge.
  always @(posedge clk) begin
    ack_at_edge <= imem_ack_i;
  end

  always @(negedge clk) begin
    if (!rst_i && imem_req_o && !prev_req && ack_at_edge) begin
      check_errors++;
      $display("%0t ns: a new fetch request began while the ack was still high", $time);
    end
    prev_req <= imem_req_o;
    if (!rst_i && retire_valid_o) begin
      check_retire();
    end
  end

  // instruction memory, answering with random delays.
  initial begin : mem_responder
    int    cnt;
    int    delay;
    logic  running;
    xlen_t addr;
    inst_t inst;
    running = 1'b1;
    cnt     = 0;
    @(negedge clk);
    while (rst_i && cnt < 20) begin
      @(negedge clk);
      cnt++;
    end
    if (rst_i) begin
      $display("timeout: reset still active after %0d cycles", cnt);
      timeout_errors++;
      stop_run = 1'b1;
      running  = 1'b0;
    end
    while (running) begin
      cnt = 0;
      while (!imem_req_o && !halt_o && cnt < WAIT_LIMIT) begin
        @(negedge clk);
        cnt++;
      end
      if (halt_o) begin
        running = 1'b0;
      end else if (!imem_req_o) begin
        $display("timeout: no fetch request within %0d cycles", WAIT_LIMIT);
        timeout_errors++;
        stop_run = 1'b1;
        running  = 1'b0;
      end else begin
        addr = imem_addr_o;
        if (addr !== model_pc) begin
          report_mismatch("imem_addr_o", model_pc, addr);
        end
        if (retire_count >= EBREAK_AFTER) begin
          inst = EBREAK_WORD;
        end else if (imem.exists(addr)) begin
          inst = imem[addr];
        end else begin
          inst       = gen_inst();
          imem[addr] = inst;
        end
        served_inst = inst;
        served_count++;
        delay = rand_range(4);
        repeat (delay) @(negedge clk);
        imem_data_i = inst;
        imem_ack_i  = 1'b1;
        cnt = 0;
        while (imem_req_o && cnt < WAIT_LIMIT) begin
          @(negedge clk);
          cnt++;
        end
        if (imem_req_o) begin
          $display("timeout: fetch request was not dropped after the ack");
          timeout_errors++;
          stop_run = 1'b1;
          running  = 1'b0;
        end else begin
          delay = rand_range(4);
          repeat (delay) @(negedge clk);
          imem_ack_i = 1'b0;
        end
      end
    end
  end

  initial begin : main_seq
    int cycles;
    clk            = 1'b0;
    rst_i          = 1'b1;
    imem_ack_i     = 1'b0;
    imem_data_i    = '0;
    seed           = 30;
    check_errors   = 0;
    timeout_errors = 0;
    retire_count   = 0;
    served_count   = 0;
    stop_run       = 1'b0;
    ebreak_retired = 1'b0;
    served_inst    = '0;
    model_pc       = START_PC;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 64'd0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;
    if (imem_req_o !== 1'b0) begin
      report_mismatch("imem_req_o", 64'd0, 64'(imem_req_o));
    end
    if (retire_valid_o !== 1'b0) begin
      report_mismatch("retire_valid_o", 64'd0, 64'(retire_valid_o));
    end
    if (halt_o !== 1'b0) begin
      report_mismatch("halt_o", 64'd0, 64'(halt_o));
    end
    if (imem_addr_o !== START_PC) begin
      report_mismatch("imem_addr_o", START_PC, imem_addr_o);
    end
    cycles = 0;
    while (!ebreak_retired && !stop_run && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!ebreak_retired && !stop_run) begin
      $display("timeout: core did not retire ebreak within %0d cycles", RUN_LIMIT);
      timeout_errors++;
    end
    if (ebreak_retired) begin
      @(negedge clk);
      if (halt_o !== 1'b1) begin
        report_mismatch("halt_o", 64'd1, 64'(halt_o));
      end
      // the halted core must stay quiet.
      for (int i = 0; i < 50; i++) begin
        @(negedge clk);
        if (imem_req_o !== 1'b0) begin
          report_mismatch("imem_req_o", 64'd0, 64'(imem_req_o));
        end
      end
      if (retire_count != served_count) begin
        report_mismatch("retire count", 64'(served_count), 64'(retire_count));
      end
    end
    end_run();
  end

endmodule

`default_nettype wire

/* rv64_core.f */
logic/rv64_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/gpr_if.sv
logic/pc_fetch.sv
logic/inst_decode.sv
logic/alu.sv
logic/gpr.sv
logic/rv64_core.sv
verif/rv64_core_props.sv
verif/rv64_core_tb.sv

/* Makefile */
SIM      := verilator
TOP      := rv64_core_tb
FILELIST := rv64_core.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
FAIL_MSG := Verification failed
SRCS     := $(shell cat $(FILELIST))

SHELL := /bin/bash

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	set -o pipefail; ./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported errors"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
